/* common/mq_pkg.sv */
package mq_pkg;

  // sizes
  localparam int num_queues  = 8;
  localparam int num_entries = 64;
  localparam int data_width  = 32;

  localparam int qid_width = $clog2(num_queues);
  localparam int ptr_width = $clog2(num_entries);
  // count must reach num_entries itself
  localparam int cnt_width = $clog2(num_entries + 1);

  // vectors with a meaning
  typedef logic [qid_width-1:0]  qid_t;
  typedef logic [ptr_width-1:0]  ptr_t;
  typedef logic [cnt_width-1:0]  cnt_t;
  typedef logic [data_width-1:0] data_t;

  // one push request
  typedef struct packed {
    qid_t  prt;
    ptr_t  ptr;
    data_t din;
  } push_req_t;

  // per-queue state, also the status port word
  typedef struct packed {
    cnt_t cnt;
    ptr_t head;
    ptr_t tail;
  } queue_stat_t;

endpackage

/* logic/mq_ram_1r1w.sv */
`timescale 1ns/1ps

module mq_ram_1r1w #(
  parameter int width = 32,
  parameter int depth = 64
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] wa,
  input  logic [width-1:0]         wd,
  input  logic                     re,
  input  logic [$clog2(depth)-1:0] ra,
  output logic [width-1:0]         rd
);

  logic [width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wa] <= wd;
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk) begin
    if (re) begin
      rd <= mem[ra];
    end
  end

endmodule

/* queue_ctrl/mq_state_table.sv */
`timescale 1ns/1ps

module mq_state_table (
  input  logic                clk,
  input  logic                rst_n,

  // combinational read views
  input  mq_pkg::qid_t        pu_qid,
  input  mq_pkg::qid_t        po_qid,
  output mq_pkg::queue_stat_t pu_cur,
  output mq_pkg::queue_stat_t po_cur,

  // full state write from push
  input  logic                pu_wr,
  input  mq_pkg::queue_stat_t pu_stat,

  // count write from pop
  input  logic                po_wr,
  input  mq_pkg::cnt_t        po_cnt,

  // delayed head write from the pop pipeline
  input  logic                hd_wr,
  input  mq_pkg::qid_t        hd_qid,
  input  mq_pkg::ptr_t        hd_ptr,

  output logic                ready,

  // status port
  input  logic                cp_read,
  input  mq_pkg::qid_t        cp_adr,
  output logic                cp_vld,
  output mq_pkg::queue_stat_t cp_dout
);

  typedef enum logic {
    st_init,
    st_run
  } init_state_t;

  init_state_t         state_q;
  mq_pkg::qid_t        init_qid;
  mq_pkg::queue_stat_t stat_q [mq_pkg::num_queues];

  // clearing sweep, one queue per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= st_init;
      init_qid <= '0;
    end else if (state_q == st_init) begin
      init_qid <= mq_pkg::qid_t'(init_qid + 1'b1);
      if (init_qid == mq_pkg::qid_t'(mq_pkg::num_queues - 1)) begin
        state_q <= st_run;
      end
    end
  end

  assign ready = (state_q == st_run);

  always_ff @(posedge clk) begin
    if (state_q == st_init) begin
      stat_q[init_qid] <= '0;
    end else begin
      if (pu_wr) begin
        stat_q[pu_qid] <= pu_stat;
      end
      if (po_wr) begin
        stat_q[po_qid].cnt <= po_cnt;
      end
      // pending head goes last, a push to a non-empty queue keeps the old head
      if (hd_wr) begin
        stat_q[hd_qid].head <= hd_ptr;
      end
    end
  end

  assign pu_cur = stat_q[pu_qid];
  assign po_cur = stat_q[po_qid];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cp_vld <= 1'b0;
    end else begin
      cp_vld <= cp_read && (state_q == st_run);
    end
  end

  always_ff @(posedge clk) begin
    if (cp_read) begin
      cp_dout <= stat_q[cp_adr];
    end
  end

endmodule

/* queue_ctrl/mq_queue_ctrl.sv */
`timescale 1ns/1ps

module mq_queue_ctrl (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                push,
  input  mq_pkg::push_req_t   push_req,
  input  logic                pop,
  input  mq_pkg::qid_t        pop_prt,

  // current state of the push and pop queues
  input  mq_pkg::queue_stat_t pu_cur,
  input  mq_pkg::queue_stat_t po_cur,

  // state table writes
  output logic                pu_wr,
  output mq_pkg::queue_stat_t pu_stat,
  output logic                po_wr,
  output mq_pkg::cnt_t        po_cnt_next,
  output logic                hd_wr,
  output mq_pkg::qid_t        hd_qid,
  output mq_pkg::ptr_t        hd_ptr,

  // link memory
  output logic                link_we,
  output mq_pkg::ptr_t        link_wa,
  output mq_pkg::ptr_t        link_wd,
  output logic                link_re,
  output mq_pkg::ptr_t        link_ra,
  input  mq_pkg::ptr_t        link_rd_data,

  // data memory
  output logic                data_we,
  output mq_pkg::ptr_t        data_wa,
  output mq_pkg::data_t       data_wd,
  output logic                data_re,
  output mq_pkg::ptr_t        data_ra,
  input  mq_pkg::data_t       data_rd_data,

  // results
  output logic                pu_cvld,
  output mq_pkg::cnt_t        pu_cnt,
  output logic                po_cvld,
  output logic                po_empty,
  output mq_pkg::cnt_t        po_cnt,
  output logic                po_pvld,
  output mq_pkg::ptr_t        po_ptr,
  output logic                po_dvld,
  output mq_pkg::data_t       po_dout
);

  mq_pkg::queue_stat_t pu_next;
  logic                po_nonempty;

  // pop stage 1
  logic                s1_vld;
  logic                s1_empty;
  logic                s1_hd_pend;
  mq_pkg::qid_t        s1_qid;
  mq_pkg::cnt_t        s1_cnt;
  mq_pkg::ptr_t        s1_ptr;

  // pop stage 2
  logic                s2_dvld;
  mq_pkg::data_t       s2_dout;

  // push appends at the tail, head only moves on an empty queue
  always_comb begin
    pu_next      = pu_cur;
    pu_next.cnt  = mq_pkg::cnt_t'(pu_cur.cnt + 1'b1);
    pu_next.tail = push_req.ptr;
    if (pu_cur.cnt == '0) begin
      pu_next.head = push_req.ptr;
    end
  end

  assign pu_wr   = push;
  assign pu_stat = pu_next;

  // old tail points at the new entry
  assign link_we = push && (pu_cur.cnt != '0);
  assign link_wa = pu_cur.tail;
  assign link_wd = push_req.ptr;

  assign data_we = push;
  assign data_wa = push_req.ptr;
  assign data_wd = push_req.din;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pu_cvld <= 1'b0;
    end else begin
      pu_cvld <= push;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pu_cnt <= pu_next.cnt;
    end
  end

  // pop side
  assign po_nonempty = (po_cur.cnt != '0);
  assign po_cnt_next = mq_pkg::cnt_t'(po_cur.cnt - 1'b1);
  assign po_wr       = pop && po_nonempty;

  assign link_re = pop && po_nonempty;
  assign link_ra = po_cur.head;
  assign data_re = pop && po_nonempty;
  assign data_ra = po_cur.head;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld     <= 1'b0;
      s1_hd_pend <= 1'b0;
      s2_dvld    <= 1'b0;
    end else begin
      s1_vld     <= pop;
      s1_hd_pend <= pop && po_nonempty && (po_cnt_next != '0);
      s2_dvld    <= s1_vld && !s1_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      s1_qid   <= pop_prt;
      s1_empty <= !po_nonempty;
      s1_cnt   <= po_nonempty ? po_cnt_next : '0;
      s1_ptr   <= po_cur.head;
    end
    // ram output moves on with the next read
    if (s1_vld) begin
      s2_dout <= data_rd_data;
    end
  end

  // next head arrives from the link read
  assign hd_wr  = s1_hd_pend;
  assign hd_qid = s1_qid;
  assign hd_ptr = link_rd_data;

  assign po_cvld  = s1_vld;
  assign po_empty = s1_empty;
  assign po_cnt   = s1_cnt;
  assign po_pvld  = s1_vld && !s1_empty;
  assign po_ptr   = s1_ptr;
  assign po_dvld  = s2_dvld;
  assign po_dout  = s2_dout;

endmodule

/* logic/mq_top.sv */
`timescale 1ns/1ps

module mq_top (
  input  logic                clk,
  input  logic                rst_n,
  output logic                ready,

  input  logic                push,
  input  mq_pkg::push_req_t   push_req,
  output logic                pu_cvld,
  output mq_pkg::cnt_t        pu_cnt,

  input  logic                pop,
  input  mq_pkg::qid_t        pop_prt,
  output logic                po_cvld,
  output logic                po_empty,
  output mq_pkg::cnt_t        po_cnt,
  output logic                po_pvld,
  output mq_pkg::ptr_t        po_ptr,
  output logic                po_dvld,
  output mq_pkg::data_t       po_dout,

  input  logic                cp_read,
  input  mq_pkg::qid_t        cp_adr,
  output logic                cp_vld,
  output mq_pkg::queue_stat_t cp_dout
);

  mq_pkg::queue_stat_t pu_cur;
  mq_pkg::queue_stat_t po_cur;
  mq_pkg::queue_stat_t pu_stat;
  logic                pu_wr;
  logic                po_wr;
  mq_pkg::cnt_t        po_cnt_next;
  logic                hd_wr;
  mq_pkg::qid_t        hd_qid;
  mq_pkg::ptr_t        hd_ptr;

  logic                link_we;
  mq_pkg::ptr_t        link_wa;
  mq_pkg::ptr_t        link_wd;
  logic                link_re;
  mq_pkg::ptr_t        link_ra;
  mq_pkg::ptr_t        link_rd_data;

  logic                data_we;
  mq_pkg::ptr_t        data_wa;
  mq_pkg::data_t       data_wd;
  logic                data_re;
  mq_pkg::ptr_t        data_ra;
  mq_pkg::data_t       data_rd_data;

  mq_state_table state_table (
    .clk     (clk),
    .rst_n   (rst_n),
    .pu_qid  (push_req.prt),
    .po_qid  (pop_prt),
    .pu_cur  (pu_cur),
    .po_cur  (po_cur),
    .pu_wr   (pu_wr),
    .pu_stat (pu_stat),
    .po_wr   (po_wr),
    .po_cnt  (po_cnt_next),
    .hd_wr   (hd_wr),
    .hd_qid  (hd_qid),
    .hd_ptr  (hd_ptr),
    .ready   (ready),
    .cp_read (cp_read),
    .cp_adr  (cp_adr),
    .cp_vld  (cp_vld),
    .cp_dout (cp_dout)
  );

  mq_queue_ctrl queue_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_req     (push_req),
    .pop          (pop),
    .pop_prt      (pop_prt),
    .pu_cur       (pu_cur),
    .po_cur       (po_cur),
    .pu_wr        (pu_wr),
    .pu_stat      (pu_stat),
    .po_wr        (po_wr),
    .po_cnt_next  (po_cnt_next),
    .hd_wr        (hd_wr),
    .hd_qid       (hd_qid),
    .hd_ptr       (hd_ptr),
    .link_we      (link_we),
    .link_wa      (link_wa),
    .link_wd      (link_wd),
    .link_re      (link_re),
    .link_ra      (link_ra),
    .link_rd_data (link_rd_data),
    .data_we      (data_we),
    .data_wa      (data_wa),
    .data_wd      (data_wd),
    .data_re      (data_re),
    .data_ra      (data_ra),
    .data_rd_data (data_rd_data),
    .pu_cvld      (pu_cvld),
    .pu_cnt       (pu_cnt),
    .po_cvld      (po_cvld),
    .po_empty     (po_empty),
    .po_cnt       (po_cnt),
    .po_pvld      (po_pvld),
    .po_ptr       (po_ptr),
    .po_dvld      (po_dvld),
    .po_dout      (po_dout)
  );

  // next pointer of each slot
  mq_ram_1r1w #(
    .width (mq_pkg::ptr_width),
    .depth (mq_pkg::num_entries)
  ) link_ram (
    .clk (clk),
    .we  (link_we),
    .wa  (link_wa),
    .wd  (link_wd),
    .re  (link_re),
    .ra  (link_ra),
    .rd  (link_rd_data)
  );

  mq_ram_1r1w #(
    .width (mq_pkg::data_width),
    .depth (mq_pkg::num_entries)
  ) data_ram (
    .clk (clk),
    .we  (data_we),
    .wa  (data_wa),
    .wd  (data_wd),
    .re  (data_re),
    .ra  (data_ra),
    .rd  (data_rd_data)
  );

endmodule

/* testbench/tb_mq_tasks.svh */
// one clock of stimulus, the model follows the buffer rules
task automatic drive_cycle(input logic do_push, input mq_pkg::qid_t pq,
                           input logic do_pop, input mq_pkg::qid_t oq);
  mq_pkg::ptr_t  p;
  mq_pkg::data_t d;
  int            slot;
  @(posedge clk);
  push <= do_push;
  pop  <= do_pop;
  if (do_push) begin
    p    = free_list.pop_front();
    d    = $urandom();
    slot = (ref_rd[pq] + ref_cnt[pq]) % mq_pkg::num_entries;
    ref_ptr[pq][slot]  = p;
    ref_data[pq][slot] = d;
    ref_cnt[pq]++;
    push_req <= '{prt: pq, ptr: p, din: d};
    pu_exp.push_back('{due: cyc + 2, cnt: mq_pkg::cnt_t'(ref_cnt[pq])});
  end
  if (do_pop) begin
    pop_prt <= oq;
    if (ref_cnt[oq] == 0) begin
      po_exp.push_back('{due: cyc + 2, empty: 1'b1, cnt: '0, ptr: '0});
    end else begin
      p = ref_ptr[oq][ref_rd[oq]];
      d = ref_data[oq][ref_rd[oq]];
      ref_rd[oq] = (ref_rd[oq] + 1) % mq_pkg::num_entries;
      ref_cnt[oq]--;
      po_exp.push_back('{due: cyc + 2, empty: 1'b0,
                         cnt: mq_pkg::cnt_t'(ref_cnt[oq]), ptr: p});
      dout_exp.push_back('{due: cyc + 3, dout: d});
      free_list.push_back(p);
    end
  end
endtask

task automatic wait_drain();
  int n;
  drive_cycle(1'b0, '0, 1'b0, '0);
  n = 0;
  while ((pu_exp.size() + po_exp.size() + dout_exp.size()) != 0 && n < 10) begin
    @(negedge clk);
    n++;
  end
  check_true((pu_exp.size() + po_exp.size() + dout_exp.size()) == 0,
             "results still outstanding after the drain timeout");
endtask

task automatic reset_and_wait_ready();
  int n;
  repeat (16) @(posedge clk);
  rst_n <= 1'b1;
  n = 0;
  while (!ready && n < 50) begin
    @(negedge clk);
    check_value("pu_cvld", 64'(pu_cvld), 64'(1'b0));
    check_value("po_cvld", 64'(po_cvld), 64'(1'b0));
    check_value("po_dvld", 64'(po_dvld), 64'(1'b0));
    check_value("cp_vld", 64'(cp_vld), 64'(1'b0));
    n++;
  end
  check_true(ready, "ready did not rise after reset");
  check_true(n >= 8, "ready rose before the clearing sweep could finish");
endtask

task automatic push_count_check();
  for (int i = 0; i < 5; i++) begin
    drive_cycle(1'b1, mq_pkg::qid_t'(5), 1'b0, '0);
  end
  wait_drain();
endtask

// three queues filled, then popped round robin
task automatic fifo_order_check();
  mq_pkg::qid_t qs [3];
  qs = '{mq_pkg::qid_t'(0), mq_pkg::qid_t'(1), mq_pkg::qid_t'(3)};
  for (int i = 0; i < 4; i++) begin
    foreach (qs[k]) drive_cycle(1'b1, qs[k], 1'b0, '0);
  end
  for (int i = 0; i < 4; i++) begin
    foreach (qs[k]) drive_cycle(1'b0, '0, 1'b1, qs[k]);
  end
  wait_drain();
endtask

task automatic empty_pop_check();
  drive_cycle(1'b0, '0, 1'b1, mq_pkg::qid_t'(7));
  drive_cycle(1'b0, '0, 1'b1, mq_pkg::qid_t'(0));
  wait_drain();
endtask

task automatic status_check();
  int tail_slot;
  for (int q = 0; q < mq_pkg::num_queues; q++) begin
    @(posedge clk);
    cp_read <= 1'b1;
    cp_adr  <= mq_pkg::qid_t'(q);
    @(posedge clk);
    cp_read <= 1'b0;
    @(negedge clk);
    check_true(cp_vld, "cp_vld did not rise one cycle after cp_read");
    check_value("cp_dout.cnt", 64'(cp_dout.cnt), 64'(ref_cnt[q]));
    // head and tail are stale on an empty queue
    if (ref_cnt[q] != 0) begin
      tail_slot = (ref_rd[q] + ref_cnt[q] - 1) % mq_pkg::num_entries;
      check_value("cp_dout.head", 64'(cp_dout.head), 64'(ref_ptr[q][ref_rd[q]]));
      check_value("cp_dout.tail", 64'(cp_dout.tail), 64'(ref_ptr[q][tail_slot]));
    end
  end
endtask

task automatic random_traffic(input int n_cycles);
  logic         do_push;
  logic         do_pop;
  logic         last_pop;
  mq_pkg::qid_t pq;
  mq_pkg::qid_t oq;
  mq_pkg::qid_t last_oq;
  last_pop = 1'b0;
  last_oq  = '0;
  for (int i = 0; i < n_cycles; i++) begin
    pq      = mq_pkg::qid_t'($urandom_range(mq_pkg::num_queues - 1));
    oq      = mq_pkg::qid_t'($urandom_range(mq_pkg::num_queues - 1));
    do_push = ($urandom_range(99) < 55) && (free_list.size() != 0);
    // no back-to-back pops to one queue
    do_pop  = ($urandom_range(99) < 50) && !(last_pop && oq == last_oq);
    if (do_push && do_pop && pq == oq) begin
      do_pop = 1'b0;
    end
    drive_cycle(do_push, pq, do_pop, oq);
    last_pop = do_pop;
    last_oq  = oq;
  end
  wait_drain();
endtask

/* testbench/tb_mq_top.sv */
`timescale 1ns/1ps

module tb_mq_top;

  typedef struct packed {
    int unsigned  due;
    mq_pkg::cnt_t cnt;
  } push_exp_t;

  typedef struct packed {
    int unsigned  due;
    logic         empty;
    mq_pkg::cnt_t cnt;
    mq_pkg::ptr_t ptr;
  } pop_exp_t;

  typedef struct packed {
    int unsigned   due;
    mq_pkg::data_t dout;
  } data_exp_t;

  logic                clk;
  logic                rst_n;
  logic                ready;
  logic                push;
  mq_pkg::push_req_t   push_req;
  logic                pu_cvld;
  mq_pkg::cnt_t        pu_cnt;
  logic                pop;
  mq_pkg::qid_t        pop_prt;
  logic                po_cvld;
  logic                po_empty;
  mq_pkg::cnt_t        po_cnt;
  logic                po_pvld;
  mq_pkg::ptr_t        po_ptr;
  logic                po_dvld;
  mq_pkg::data_t       po_dout;
  logic                cp_read;
  mq_pkg::qid_t        cp_adr;
  logic                cp_vld;
  mq_pkg::queue_stat_t cp_dout;

  // reference model as one ring per queue
  mq_pkg::ptr_t  ref_ptr  [mq_pkg::num_queues][mq_pkg::num_entries];
  mq_pkg::data_t ref_data [mq_pkg::num_queues][mq_pkg::num_entries];
  int            ref_rd   [mq_pkg::num_queues];
  int            ref_cnt  [mq_pkg::num_queues];
  mq_pkg::ptr_t  free_list [$];

  // results still to come in issue order
  push_exp_t   pu_exp [$];
  pop_exp_t    po_exp [$];
  data_exp_t   dout_exp [$];
  int unsigned cyc = 0;

  mq_top mq_top_inst (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("error: %s", what);
      stop_run();
    end
  endtask

  // result monitor on the falling edge
  always @(negedge clk) begin : monitor
    push_exp_t pe;
    pop_exp_t  oe;
    data_exp_t de;
    if (pu_cvld) begin
      check_true(pu_exp.size() != 0, "pu_cvld rose with no push outstanding");
      pe = pu_exp.pop_front();
      check_true(pe.due == cyc, "pu_cvld rose in the wrong cycle");
      check_value("pu_cnt", 64'(pu_cnt), 64'(pe.cnt));
    end else if (pu_exp.size() != 0) begin
      check_true(pu_exp[0].due > cyc, "pu_cvld did not rise one cycle after push");
    end
    if (po_cvld) begin
      check_true(po_exp.size() != 0, "po_cvld rose with no pop outstanding");
      oe = po_exp.pop_front();
      check_true(oe.due == cyc, "po_cvld rose in the wrong cycle");
      check_value("po_empty", 64'(po_empty), 64'(oe.empty));
      check_value("po_cnt", 64'(po_cnt), 64'(oe.cnt));
      check_value("po_pvld", 64'(po_pvld), 64'(!oe.empty));
      if (!oe.empty) begin
        check_value("po_ptr", 64'(po_ptr), 64'(oe.ptr));
      end
    end else begin
      check_value("po_pvld", 64'(po_pvld), 64'(1'b0));
      if (po_exp.size() != 0) begin
        check_true(po_exp[0].due > cyc, "po_cvld did not rise one cycle after pop");
      end
    end
    if (po_dvld) begin
      check_true(dout_exp.size() != 0, "po_dvld rose with no data outstanding");
      de = dout_exp.pop_front();
      check_true(de.due == cyc, "po_dvld rose in the wrong cycle");
      check_value("po_dout", 64'(po_dout), 64'(de.dout));
    end else if (dout_exp.size() != 0) begin
      check_true(dout_exp[0].due > cyc, "po_dvld did not rise two cycles after pop");
    end
  end

  `include "tb_mq_tasks.svh"

  initial begin
    void'($urandom(32'h16ae));
    clk      = 1'b0;
    rst_n    = 1'b0;
    push     = 1'b0;
    push_req = '0;
    pop      = 1'b0;
    pop_prt  = '0;
    cp_read  = 1'b0;
    cp_adr   = '0;
    for (int q = 0; q < mq_pkg::num_queues; q++) begin
      ref_rd[q]  = 0;
      ref_cnt[q] = 0;
    end
    for (int i = 0; i < mq_pkg::num_entries; i++) begin
      free_list.push_back(mq_pkg::ptr_t'(i));
    end

    reset_and_wait_ready();
    push_count_check();
    fifo_order_check();
    empty_pop_check();
    status_check();
    random_traffic(2000);
    status_check();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* flist.f */
+incdir+testbench
common/mq_pkg.sv
logic/mq_ram_1r1w.sv
queue_ctrl/mq_state_table.sv
queue_ctrl/mq_queue_ctrl.sv
logic/mq_top.sv
testbench/tb_mq_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_mq_top -f flist.f \
	  --Mdir obj_dir -o tb_mq_top
	./obj_dir/tb_mq_top | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
